//--- lsuBusTop.f
+incdir+include
hw/lsuBusPkg.sv
hw/lsuRequestStage.sv
hw/busController.sv
hw/busRam.sv
hw/loadFormatter.sv
hw/lsuBusTop.sv
verification/lsuBusClock.sv
verification/lsuBusTb.sv

//--- Makefile
LOG = sim.log

.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert --top-module lsuBusTb -f lsuBusTop.f -Mdir obj_dir
	./obj_dir/VlsuBusTb | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- verification/lsuBusTb.sv
/*
  LSU bus testbench
  Runs directed and random loads and stores over the four-phase port,
  keeps a byte-wide reference memory and checks with assertions
*/
`timescale 1ns/1ps
`default_nettype none

`include "lsuBus_macros.svh"

module lsuBusTb;

  localparam int addrWidth   = `LSU_ADDR_WIDTH;
  localparam int memBytes    = `BUS_RAM_WORDS * 4;
  localparam int waitLimit   = 64;
  localparam int randomCount = 200;
  // Random traffic stays in a 128-byte window so loads hit written data
  localparam logic [addrWidth-1:0] randomBase = 'h200;

  logic                  clk;
  logic                  reset;
  logic                  req;
  lsuBusPkg::cpuRequestT request;
  logic                  ack;
  logic [31:0]           rdata;

  // Reference memory and a flag per byte that says it holds known data
  logic [7:0]  refMem [memBytes];
  bit          written [memBytes];
  logic        checkRead;
  logic [31:0] expectedData;
  logic        anyRequest;
  integer      seed;

  lsuBusClock i_lsuBusClock (
    .clk   (clk),
    .reset (reset)
  );

  lsuBusTop i_lsuBusTop (
    .clk     (clk),
    .reset   (reset),
    .req     (req),
    .request (request),
    .ack     (ack),
    .rdata   (rdata)
  );

  //////////////////////////////
  // Failure reports
  //////////////////////////////

  task automatic reportValueError(input string msg);
    $display("ERR %0t %s", $time, msg);
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped at the first failed check");
  endtask

  task automatic reportTimeout(input string what, input int cycles);
    $display("Timed out after %0d cycles while waiting for %s", cycles, what);
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped on a timeout");
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Word accesses use the aligned word with byte lane 0 in the low byte
  function automatic logic [31:0] expectedLoad(input lsuBusPkg::lsuOpE op,
                                               input logic [addrWidth-1:0] addr);
    logic [7:0] b;
    b = refMem[addr];
    case (op)
      lsuBusPkg::loadByte:         return {{24{b[7]}}, b};
      lsuBusPkg::loadByteUnsigned: return {24'h000000, b};
      default: begin
        return {refMem[{addr[addrWidth-1:2], 2'd3}], refMem[{addr[addrWidth-1:2], 2'd2}],
                refMem[{addr[addrWidth-1:2], 2'd1}], refMem[{addr[addrWidth-1:2], 2'd0}]};
      end
    endcase
  endfunction

  function automatic bit wordWritten(input logic [addrWidth-1:0] addr);
    return written[{addr[addrWidth-1:2], 2'd0}] && written[{addr[addrWidth-1:2], 2'd1}] &&
           written[{addr[addrWidth-1:2], 2'd2}] && written[{addr[addrWidth-1:2], 2'd3}];
  endfunction

  task automatic updateModel(input lsuBusPkg::lsuOpE op, input logic [addrWidth-1:0] addr,
                             input logic [31:0] data);
    if (op == lsuBusPkg::storeWord) begin
      for (int lane = 0; lane < 4; lane++) begin
        refMem[{addr[addrWidth-1:2], 2'(lane)}]  = data[lane*8 +: 8];
        written[{addr[addrWidth-1:2], 2'(lane)}] = 1'b1;
      end
    end else if (op == lsuBusPkg::storeByte) begin
      // Only the low byte of the store data matters for a byte store
      refMem[addr]  = data[7:0];
      written[addr] = 1'b1;
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // All waits resume 1 ns after the edge, where inputs are also driven
  task automatic waitForAck(input logic level, input string what);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > waitLimit) reportTimeout(what, cycles);
    end while (ack !== level);
  endtask

  task automatic waitForReset();
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > waitLimit) reportTimeout("reset to be released", cycles);
    end while (reset !== 1'b0);
  endtask

  task automatic idleCycles(input int count);
    repeat (count) begin
      @(posedge clk);
      #1;
    end
  endtask

  // One full four-phase access
  task automatic runAccess(input lsuBusPkg::lsuOpE op, input logic [addrWidth-1:0] addr,
                           input logic [31:0] data);
    logic isLoad;
    isLoad = (op == lsuBusPkg::loadWord) || (op == lsuBusPkg::loadByte) ||
             (op == lsuBusPkg::loadByteUnsigned);
    if (isLoad) begin
      expectedData = expectedLoad(op, addr);
      checkRead    = 1'b1;
    end else begin
      checkRead = 1'b0;
    end
    request.op        = op;
    request.addr      = addr;
    request.storeData = data;
    req               = 1'b1;
    anyRequest        = 1'b1;
    waitForAck(1'b1, "ack to rise");
    // req stays up one more cycle so ack is seen holding against it
    idleCycles(1);
    req = 1'b0;
    waitForAck(1'b0, "ack to fall");
    if (!isLoad) updateModel(op, addr, data);
  endtask

  task automatic randomAccess();
    int                   pick;
    logic [6:0]           offset;
    logic [addrWidth-1:0] addr;
    logic [31:0]          data;
    lsuBusPkg::lsuOpE     op;
    pick   = $unsigned($random(seed)) % 5;
    offset = 7'($random(seed));
    data   = $random(seed);
    addr   = randomBase + addrWidth'(offset);
    case (pick)
      0:       op = lsuBusPkg::loadWord;
      1:       op = lsuBusPkg::loadByte;
      2:       op = lsuBusPkg::loadByteUnsigned;
      3:       op = lsuBusPkg::storeWord;
      default: op = lsuBusPkg::storeByte;
    endcase
    if (op == lsuBusPkg::loadWord || op == lsuBusPkg::storeWord) begin
      addr[1:0] = 2'b00;
    end
    // A load of unknown bytes becomes a store of the same size
    if (op == lsuBusPkg::loadWord && !wordWritten(addr)) begin
      op = lsuBusPkg::storeWord;
    end else if ((op == lsuBusPkg::loadByte || op == lsuBusPkg::loadByteUnsigned) &&
                 !written[addr]) begin
      op = lsuBusPkg::storeByte;
    end
    runAccess(op, addr, data);
  endtask

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Nothing is acknowledged before the first request
  quietBeforeRequest: assert property (@(posedge clk) disable iff (reset)
    !anyRequest |-> !ack)
    else reportValueError("ack high before any request was issued");

  // ack only rises out of a cycle in which req was high
  ackNeedsReq: assert property (@(posedge clk) disable iff (reset)
    $rose(ack) |-> $past(req))
    else reportValueError("ack rose while req was low");

  // While req is still held the acknowledge does not go away
  ackHeld: assert property (@(posedge clk) disable iff (reset)
    (ack && req) |=> ack)
    else reportValueError("ack fell before req was dropped");

  // Two cycles of low req leave ack low from then on
  ackReleased: assert property (@(posedge clk) disable iff (reset)
    (!req && $past(!req)) |=> !ack)
    else reportValueError("ack still high after req was dropped");

  loadData: assert property (@(posedge clk) disable iff (reset)
    (ack && checkRead) |-> (rdata == expectedData))
    else reportValueError($sformatf("load returned %h, expected %h",
                                    $sampled(rdata), $sampled(expectedData)));

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    seed         = 32'h1315;
    req          = 1'b0;
    request      = '0;
    checkRead    = 1'b0;
    expectedData = '0;
    anyRequest   = 1'b0;
    for (int i = 0; i < memBytes; i++) begin
      refMem[i]  = '0;
      written[i] = 1'b0;
    end

    waitForReset();
    // A few idle cycles to see ack stay quiet
    idleCycles(6);

    // Word store then word load at the same address
    runAccess(lsuBusPkg::storeWord, 10'h040, 32'hCAFEF00D);
    runAccess(lsuBusPkg::loadWord, 10'h040, 32'h0);
    runAccess(lsuBusPkg::storeWord, 10'h3FC, 32'h0BADBEEF);
    runAccess(lsuBusPkg::loadWord, 10'h3FC, 32'h0);

    // Byte store into a known word touches one lane only
    runAccess(lsuBusPkg::storeWord, 10'h080, 32'h11223344);
    runAccess(lsuBusPkg::storeByte, 10'h082, 32'h000000AB);
    runAccess(lsuBusPkg::loadWord, 10'h080, 32'h0);

    // Top bit set in the byte, signed then unsigned
    runAccess(lsuBusPkg::storeByte, 10'h093, 32'h0000009C);
    runAccess(lsuBusPkg::loadByte, 10'h093, 32'h0);
    runAccess(lsuBusPkg::loadByteUnsigned, 10'h093, 32'h0);

    for (int n = 0; n < randomCount; n++) begin
      randomAccess();
    end

    idleCycles(4);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/lsuBusClock.sv
/*
  LSU bus testbench clock
  Free-running 40 ns clock and a synchronous reset held for 8 cycles
*/
`timescale 1ns/1ps
`default_nettype none

module lsuBusClock (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Reset drops just after an edge, like every other driven input
  initial begin
    reset = 1'b1;
    repeat (8) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

`default_nettype wire

//--- hw/lsuBusTop.sv
/*
  LSU bus top
  Connects the request stage, bus controller, bus RAM and load formatter
  behind a four-phase req and ack interface to the core
*/
`timescale 1ns/1ps
`default_nettype none

`include "lsuBus_macros.svh"

module lsuBusTop (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req,
  input  lsuBusPkg::cpuRequestT request,
  output logic                  ack,
  output logic [31:0]           rdata
);

  // Request stage to controller
  logic                  valid;
  logic                  done;
  lsuBusPkg::busRequestT busRequest;

  // Bus between controller and RAM
  lsuBusPkg::htransE          HTRANS;
  logic                       HWRITE;
  logic [`LSU_ADDR_WIDTH-3:0] HADDR;
  logic [3:0]                 HBYTEEN;
  logic [31:0]                HWDATA;
  logic                       HREADY;
  logic [31:0]                HRDATA;

  // Controller to load formatter
  logic               complete;
  lsuBusPkg::busWordU readWord;
  lsuBusPkg::lsuOpE   op;
  logic [1:0]         byteOffset;

  lsuRequestStage i_lsuRequestStage (
    .clk        (clk),
    .reset      (reset),
    .req        (req),
    .request    (request),
    .done       (done),
    .valid      (valid),
    .busRequest (busRequest)
  );

  busController i_busController (
    .clk        (clk),
    .reset      (reset),
    .valid      (valid),
    .busRequest (busRequest),
    .HREADY     (HREADY),
    .HRDATA     (HRDATA),
    .HTRANS     (HTRANS),
    .HWRITE     (HWRITE),
    .HADDR      (HADDR),
    .HBYTEEN    (HBYTEEN),
    .HWDATA     (HWDATA),
    .done       (done),
    .complete   (complete),
    .readWord   (readWord),
    .op         (op),
    .byteOffset (byteOffset)
  );

  busRam i_busRam (
    .clk     (clk),
    .reset   (reset),
    .HTRANS  (HTRANS),
    .HWRITE  (HWRITE),
    .HADDR   (HADDR),
    .HBYTEEN (HBYTEEN),
    .HWDATA  (HWDATA),
    .HREADY  (HREADY),
    .HRDATA  (HRDATA)
  );

  loadFormatter i_loadFormatter (
    .clk        (clk),
    .reset      (reset),
    .complete   (complete),
    .readWord   (readWord),
    .op         (op),
    .byteOffset (byteOffset),
    .ack        (ack),
    .rdata      (rdata)
  );

endmodule

`default_nettype wire

//--- hw/loadFormatter.sv
/*
  Load formatter
  Picks the addressed byte or the whole word from the bus result,
  extends it and returns it to the core with the acknowledge
*/
`timescale 1ns/1ps
`default_nettype none

module loadFormatter (
  input  logic               clk,
  input  logic               reset,
  input  logic               complete,
  input  lsuBusPkg::busWordU readWord,
  input  lsuBusPkg::lsuOpE   op,
  input  logic [1:0]         byteOffset,
  output logic               ack,
  output logic [31:0]        rdata
);

  logic [7:0] selectedByte;

  //////////////////////////////
  // Data select
  //////////////////////////////

  // Byte lane chosen by the low address bits
  assign selectedByte = readWord.bytes[byteOffset];

  always_comb begin
    case (op)
      lsuBusPkg::loadByte: begin
        rdata = {{24{selectedByte[7]}}, selectedByte};
      end
      lsuBusPkg::loadByteUnsigned: begin
        rdata = {24'h000000, selectedByte};
      end
      // Word loads and stores pass the whole word
      default: begin
        rdata = readWord.word;
      end
    endcase
  end

  //////////////////////////////
  // Acknowledge
  //////////////////////////////

  // ack trails complete by one cycle on both edges
  always_ff @(posedge clk) begin
    if (reset) begin
      ack <= 1'b0;
    end else begin
      ack <= complete;
    end
  end

  // The core may sample rdata in any cycle while ack is high
  rdataHeld: assert property (@(posedge clk) disable iff (reset)
    (ack && $past(ack)) |-> $stable(rdata));

endmodule

`default_nettype wire

//--- hw/busRam.sv
/*
  Bus RAM
  On-chip slave memory that answers each transfer after a fixed number
  of wait states and writes only the enabled byte lanes
*/
`timescale 1ns/1ps
`default_nettype none

`include "lsuBus_macros.svh"

module busRam (
  input  logic                       clk,
  input  logic                       reset,
  input  lsuBusPkg::htransE          HTRANS,
  input  logic                       HWRITE,
  input  logic [`LSU_ADDR_WIDTH-3:0] HADDR,
  input  logic [3:0]                 HBYTEEN,
  input  logic [31:0]                HWDATA,
  output logic                       HREADY,
  output logic [31:0]                HRDATA
);

  // Counter must reach BUS_WAIT_STATES even when that is zero
  localparam int countWidth = $clog2(`BUS_WAIT_STATES + 2);
  localparam int indexWidth = $clog2(`BUS_RAM_WORDS);

  logic [31:0]           mem [`BUS_RAM_WORDS];
  logic [countWidth-1:0] waitCount;
  logic [indexWidth-1:0] index;
  logic                  active;

  assign active = (HTRANS == lsuBusPkg::nonSeq);
  assign index  = HADDR[indexWidth-1:0];

  //////////////////////////////
  // Wait states
  //////////////////////////////

  // Counts the cycles of the current transfer
  // and goes back to zero once it completes
  always_ff @(posedge clk) begin
    if (reset) begin
      waitCount <= '0;
    end else if (active && !HREADY) begin
      waitCount <= waitCount + 1'b1;
    end else begin
      waitCount <= '0;
    end
  end

  assign HREADY = active && (waitCount == countWidth'(`BUS_WAIT_STATES));

  //////////////////////////////
  // Storage
  //////////////////////////////

  // Writes land at the end of the HREADY cycle
  always_ff @(posedge clk) begin
    if (active && HREADY && HWRITE) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (HBYTEEN[lane]) begin
          mem[index][lane*8 +: 8] <= HWDATA[lane*8 +: 8];
        end
      end
    end
  end

  // Read word is presented continuously and sampled in the HREADY cycle
  assign HRDATA = mem[index];

  // The master holds the address for the whole data phase
  addrStable: assert property (@(posedge clk) disable iff (reset)
    (active && !HREADY) |=> $stable(HADDR));

endmodule

`default_nettype wire

//--- hw/busController.sv
/*
  Bus controller
  State machine that runs one single non-burst transfer per request,
  waits out HREADY and holds the result until the handshake closes
*/
`timescale 1ns/1ps
`default_nettype none

`include "lsuBus_macros.svh"

module busController (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       valid,
  input  lsuBusPkg::busRequestT      busRequest,
  input  logic                       HREADY,
  input  logic [31:0]                HRDATA,
  output lsuBusPkg::htransE          HTRANS,
  output logic                       HWRITE,
  output logic [`LSU_ADDR_WIDTH-3:0] HADDR,
  output logic [3:0]                 HBYTEEN,
  output logic [31:0]                HWDATA,
  output logic                       done,
  output logic                       complete,
  output lsuBusPkg::busWordU         readWord,
  output lsuBusPkg::lsuOpE           op,
  output logic [1:0]                 byteOffset
);

  // Every access goes straight to the bus since there is no cache
  typedef enum logic [2:0] {
    ready,
    uncachedRead,
    uncachedWrite,
    readDone,
    writeDone
  } busStateE;

  busStateE state;
  busStateE nextState;
  logic     inTransfer;
  logic     inDone;

  //////////////////////////////
  // State machine
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ready;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      ready: begin
        if (valid && busRequest.write) begin
          nextState = uncachedWrite;
        end else if (valid) begin
          nextState = uncachedRead;
        end
      end
      uncachedRead:  if (HREADY) nextState = readDone;
      uncachedWrite: if (HREADY) nextState = writeDone;
      // Wait here until the core drops req and valid falls
      readDone, writeDone: if (!valid) nextState = ready;
      default: nextState = ready;
    endcase
  end

  assign inTransfer = (state == uncachedRead) || (state == uncachedWrite);
  assign inDone     = (state == readDone) || (state == writeDone);

  //////////////////////////////
  // Bus drive and capture
  //////////////////////////////

  // NONSEQ lasts through the cycle in which HREADY completes it
  assign HTRANS  = inTransfer ? lsuBusPkg::nonSeq : lsuBusPkg::idle;
  assign HWRITE  = (state == uncachedWrite);
  assign HADDR   = busRequest.wordAddr;
  assign HBYTEEN = busRequest.byteEn;
  assign HWDATA  = busRequest.writeData.word;

  // Read data is only good in the HREADY cycle so it is kept here
  always_ff @(posedge clk) begin
    if ((state == uncachedRead) && HREADY) begin
      readWord <= HRDATA;
    end
  end

  assign done       = inDone;
  assign complete   = inDone;
  assign op         = busRequest.op;
  assign byteOffset = busRequest.byteOffset;

  // The request stage keeps valid up for the whole transfer
  transferNeedsValid: assert property (@(posedge clk) disable iff (reset)
    inTransfer |-> valid);

  // The latched request does not move under a running transfer or a held result
  requestSteady: assert property (@(posedge clk) disable iff (reset)
    (inTransfer || inDone) |-> $stable(busRequest));

endmodule

`default_nettype wire

//--- hw/lsuRequestStage.sv
/*
  LSU request stage
  Four-phase front end that latches one core request per handshake and
  turns it into a bus request with byte enables and lane-placed data
*/
`timescale 1ns/1ps
`default_nettype none

`include "lsuBus_macros.svh"

module lsuRequestStage (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  req,
  input  lsuBusPkg::cpuRequestT request,
  input  logic                  done,
  output logic                  valid,
  output lsuBusPkg::busRequestT busRequest
);

  // Set while a request is owned by this stage
  logic held;
  logic capture;
  logic isWrite;
  logic isByte;
  lsuBusPkg::busRequestT nextRequest;

  //////////////////////////////
  // Decode
  //////////////////////////////

  // A new request is taken only when nothing is held
  assign capture = req && !held;

  assign isWrite = (request.op == lsuBusPkg::storeWord) ||
                   (request.op == lsuBusPkg::storeByte);
  assign isByte  = (request.op == lsuBusPkg::storeByte) ||
                   (request.op == lsuBusPkg::loadByte) ||
                   (request.op == lsuBusPkg::loadByteUnsigned);

  always_comb begin
    nextRequest            = '0;
    nextRequest.write      = isWrite;
    nextRequest.op         = request.op;
    nextRequest.wordAddr   = request.addr[`LSU_ADDR_WIDTH-1:2];
    nextRequest.byteOffset = request.addr[1:0];
    // Byte accesses enable a single lane picked by the low address bits
    if (isByte) begin
      nextRequest.byteEn = 4'b0001 << request.addr[1:0];
    end else begin
      nextRequest.byteEn = 4'b1111;
    end
    // Byte stores copy the byte onto every lane
    // The byte enables then pick the lane that really gets written
    if (request.op == lsuBusPkg::storeByte) begin
      for (int lane = 0; lane < 4; lane++) begin
        nextRequest.writeData.bytes[lane] = request.storeData[7:0];
      end
    end else begin
      nextRequest.writeData.word = request.storeData;
    end
  end

  //////////////////////////////
  // Handshake state
  //////////////////////////////

  // Held from capture until the transfer is done and req has dropped
  always_ff @(posedge clk) begin
    if (reset) begin
      held <= 1'b0;
    end else if (capture) begin
      held <= 1'b1;
    end else if (done && !req) begin
      held <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      busRequest <= nextRequest;
    end
  end

  // valid drops as soon as req falls after done
  // so the controller can leave its done state on the next edge
  assign valid = held && !(done && !req);

  // The core keeps its request steady up to the cycle after capture
  requestStable: assert property (@(posedge clk) disable iff (reset)
    (req && !valid) |=> (!req || $stable(request)));

endmodule

`default_nettype wire

//--- hw/lsuBusPkg.sv
/*
  LSU bus package
  Operation and transfer encodings plus the request and bus word types
  passed between the core side, the bus controller and the load formatter
*/
`default_nettype none

`include "lsuBus_macros.svh"

package lsuBusPkg;

  // Load and store operations issued by the core
  typedef enum logic [2:0] {
    loadWord         = 3'd0,
    loadByte         = 3'd1,
    loadByteUnsigned = 3'd2,
    storeWord        = 3'd3,
    storeByte        = 3'd4
  } lsuOpE;

  // AHB-style transfer type
  // Only single non-burst transfers exist so BUSY and SEQ are never used
  typedef enum logic [1:0] {
    idle   = 2'b00,
    nonSeq = 2'b10
  } htransE;

  // One bus word seen whole or as four byte lanes
  // Lane 0 sits in the low byte
  typedef union packed {
    logic [31:0]     word;
    logic [3:0][7:0] bytes;
  } busWordU;

  // Request as the core presents it
  typedef struct packed {
    lsuOpE                      op;
    logic [`LSU_ADDR_WIDTH-1:0] addr;
    logic [31:0]                storeData;
  } cpuRequestT;

  // Request after lane decode and ready for the bus
  typedef struct packed {
    logic                       write;
    logic [`LSU_ADDR_WIDTH-3:0] wordAddr;
    logic [3:0]                 byteEn;
    busWordU                    writeData;
    logic [1:0]                 byteOffset;
    lsuOpE                      op;
  } busRequestT;

endpackage

`default_nettype wire

//--- include/lsuBus_macros.svh
/*
  LSU bus path parameters
  Address width, bus RAM depth and slave wait states shared by the
  package, the RTL and the testbench
*/
`ifndef LSU_BUS_MACROS_SVH
`define LSU_BUS_MACROS_SVH

// Byte address width seen by the core
// Ten bits give a 1 KiB data space
`define LSU_ADDR_WIDTH 10

// Depth of the bus RAM in 32-bit words
// Must cover the whole byte address space divided by four
`define BUS_RAM_WORDS 256

// Cycles HREADY stays low before the data phase completes
`define BUS_WAIT_STATES 2

`endif
